//--- Makefile
# Verilator build and run for the run merger testbench.

VERILATOR ?= verilator
TOP       ?= run_merger_tb
FILELIST  ?= sources.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

test: $(EXE)
	-./$(EXE) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sources.f
+incdir+src
src/merge_pkg.sv
src/run_fifo.sv
src/merge_datapath.sv
src/merge_control.sv
src/run_merger_top.sv
verif/run_merger_chk.sv
verif/run_merger_tb.sv

//--- src/merge_control.sv
module merge_control (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_a_empty,
   input  logic                  i_b_empty,
   input  logic                  i_a_zero,    // a head is a terminator.
   input  logic                  i_b_zero,    // b head is a terminator.
   input  logic                  i_a_lte_b,
   input  logic                  i_out_full,  // downstream back-pressure.
   output merge_pkg::merge_sel_e o_sel,
   output logic                  o_a_rd,      // pop a, same cycle as o_sel.
   output logic                  o_b_rd       // pop b, same cycle as o_sel.
);

   import merge_pkg::*;

   merge_state_e state;
   merge_state_e state_nxt;
   merge_sel_e   sel;
   logic         stall;

   // no progress when downstream is full or a needed head is missing.
   always_comb begin
      case (state)
         ST_MERGE:  stall = i_out_full || i_a_empty || i_b_empty;
         ST_A_DONE: stall = i_out_full || i_b_empty;  // a sits on its terminator.
         ST_B_DONE: stall = i_out_full || i_a_empty;  // b sits on its terminator.
         default:   stall = i_out_full;
      endcase
   end

   // next state and head select.
   always_comb begin
      state_nxt = state;
      sel       = SEL_NONE;
      if (!stall) begin
         case (state)
            ST_MERGE: begin
               if (i_a_zero && i_b_zero) begin
                  sel = SEL_TERM;          // both runs ended together.
               end else if (i_a_zero) begin
                  state_nxt = ST_A_DONE;   // no pop, keep a's terminator.
               end else if (i_b_zero) begin
                  state_nxt = ST_B_DONE;
               end else if (i_a_lte_b) begin
                  sel = SEL_A;
               end else begin
                  sel = SEL_B;
               end
            end
            ST_A_DONE: begin
               if (i_b_zero) begin
                  // b reached its end, close the pair.
                  sel       = SEL_TERM;
                  state_nxt = ST_MERGE;
               end else begin
                  sel = SEL_B;             // drain rest of b.
               end
            end
            ST_B_DONE: begin
               if (i_a_zero) begin
                  sel       = SEL_TERM;
                  state_nxt = ST_MERGE;
               end else begin
                  sel = SEL_A;             // drain rest of a.
               end
            end
            default: begin
               state_nxt = ST_MERGE;       // unreachable encoding.
            end
         endcase
      end
   end

   // state register.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_MERGE;
      end else begin
         state <= state_nxt;
      end
   end

   assign o_sel = sel;

   // a pop follows the select directly.
   // the terminator pops both, one zero word goes out.
   assign o_a_rd = (sel == SEL_A) || (sel == SEL_TERM);
   assign o_b_rd = (sel == SEL_B) || (sel == SEL_TERM);

endmodule

//--- src/merge_datapath.sv
`include "merge_params.svh"

module merge_datapath (
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   input  logic [`MERGE_DATA_W-1:0] i_a_head,
   input  logic [`MERGE_DATA_W-1:0] i_b_head,
   input  merge_pkg::merge_sel_e    i_sel,       // which word to register.
   output logic                     o_a_zero,    // a head is a terminator.
   output logic                     o_b_zero,    // b head is a terminator.
   output logic                     o_a_lte_b,   // a head <= b head.
   output logic                     o_out_valid,
   output logic [`MERGE_DATA_W-1:0] o_out_data,
   output logic                     o_out_last
);

   import merge_pkg::*;

   // terminator detection.
   assign o_a_zero = (i_a_head == '0);
   assign o_b_zero = (i_b_head == '0);

   // ties go to a, keeps the merge stable.
   assign o_a_lte_b = (i_a_head <= i_b_head);

   // output strobes.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_out_valid <= 1'b0;
         o_out_last  <= 1'b0;
      end else begin
         case (i_sel)
            SEL_A, SEL_B: begin
               o_out_valid <= 1'b1;
               o_out_last  <= 1'b0;
            end
            SEL_TERM: begin
               o_out_valid <= 1'b1;
               o_out_last  <= 1'b1;  // single zero closes the run.
            end
            default: begin
               o_out_valid <= 1'b0;  // stall or state change.
               o_out_last  <= 1'b0;
            end
         endcase
      end
   end

   // output word.
   // holds its old value on idle cycles, valid tells.
   always_ff @(posedge i_clk) begin
      case (i_sel)
         SEL_A:    o_out_data <= i_a_head;
         SEL_B:    o_out_data <= i_b_head;
         SEL_TERM: o_out_data <= '0;
         default:  o_out_data <= o_out_data;
      endcase
   end

endmodule

//--- src/merge_params.svh
`ifndef MERGE_PARAMS_SVH
`define MERGE_PARAMS_SVH

// data word width, one sort key per word.
`define MERGE_DATA_W 16

// entries in each run fifo, keep it a power of two.
`define MERGE_FIFO_DEPTH 8

// log2 of the fifo depth.
`define MERGE_PTR_W 3

`endif

//--- src/merge_pkg.sv
package merge_pkg;

   // control fsm states.
   typedef enum logic [1:0] {
      ST_MERGE  = 2'b00,  // both runs still open.
      ST_A_DONE = 2'b01,  // a terminator at head, drain b.
      ST_B_DONE = 2'b10   // b terminator at head, drain a.
   } merge_state_e;

   // head select opcode, control to datapath.
   // the same code also decides which fifo gets popped.
   typedef enum logic [1:0] {
      SEL_NONE = 2'b00,  // idle or stalled.
      SEL_A    = 2'b01,  // emit and pop head of a.
      SEL_B    = 2'b10,  // emit and pop head of b.
      SEL_TERM = 2'b11   // pop both terminators, emit one zero.
   } merge_sel_e;

endpackage

//--- src/run_fifo.sv
`include "merge_params.svh"

module run_fifo (
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   input  logic                     i_wr,       // write strobe.
   input  logic [`MERGE_DATA_W-1:0] i_wr_data,
   input  logic                     i_rd,       // pops the head.
   output logic [`MERGE_DATA_W-1:0] o_rd_data,  // head word, always visible.
   output logic                     o_empty,
   output logic                     o_full
);

   localparam int CNT_W = `MERGE_PTR_W + 1;

   logic [`MERGE_DATA_W-1:0] mem [`MERGE_FIFO_DEPTH];

   logic [`MERGE_PTR_W-1:0] wr_ptr;
   logic [`MERGE_PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0]        count;   // occupancy, 0 to depth.

   logic wr_en;
   logic rd_en;

   // writes into a full fifo are lost.
   assign wr_en = i_wr && !o_full;
   // reads of an empty fifo do nothing.
   assign rd_en = i_rd && !o_empty;

   assign o_empty = (count == '0);
   assign o_full  = (count == CNT_W'(`MERGE_FIFO_DEPTH));

   // first word fall through.
   assign o_rd_data = mem[rd_ptr];

   // storage array.
   always_ff @(posedge i_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= i_wr_data;
      end
   end

   // pointers wrap naturally at the power of two depth.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // occupancy count.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         count <= '0;
      end else begin
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;  // push only.
            2'b01:   count <= count - 1'b1;  // pop only.
            default: count <= count;         // both or neither.
         endcase
      end
   end

endmodule

//--- src/run_merger_top.sv
`include "merge_params.svh"

module run_merger_top (
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   input  logic                     i_a_wr,
   input  logic [`MERGE_DATA_W-1:0] i_a_data,
   input  logic                     i_b_wr,
   input  logic [`MERGE_DATA_W-1:0] i_b_data,
   input  logic                     i_out_full,
   output logic                     o_a_full,
   output logic                     o_b_full,
   output logic                     o_out_valid,
   output logic [`MERGE_DATA_W-1:0] o_out_data,
   output logic                     o_out_last
);

   import merge_pkg::*;

   logic [`MERGE_DATA_W-1:0] a_head;
   logic [`MERGE_DATA_W-1:0] b_head;
   logic                     a_empty;
   logic                     b_empty;
   logic                     a_rd;
   logic                     b_rd;
   logic                     a_zero;
   logic                     b_zero;
   logic                     a_lte_b;
   merge_sel_e               sel;

   // stream a buffer.
   run_fifo fifo_a (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_wr      (i_a_wr),
      .i_wr_data (i_a_data),
      .i_rd      (a_rd),
      .o_rd_data (a_head),
      .o_empty   (a_empty),
      .o_full    (o_a_full)
   );

   // stream b buffer.
   run_fifo fifo_b (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_wr      (i_b_wr),
      .i_wr_data (i_b_data),
      .i_rd      (b_rd),
      .o_rd_data (b_head),
      .o_empty   (b_empty),
      .o_full    (o_b_full)
   );

   merge_datapath u_datapath (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_a_head    (a_head),
      .i_b_head    (b_head),
      .i_sel       (sel),
      .o_a_zero    (a_zero),
      .o_b_zero    (b_zero),
      .o_a_lte_b   (a_lte_b),
      .o_out_valid (o_out_valid),
      .o_out_data  (o_out_data),
      .o_out_last  (o_out_last)
   );

   merge_control u_control (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_a_empty  (a_empty),
      .i_b_empty  (b_empty),
      .i_a_zero   (a_zero),
      .i_b_zero   (b_zero),
      .i_a_lte_b  (a_lte_b),
      .i_out_full (i_out_full),
      .o_sel      (sel),
      .o_a_rd     (a_rd),
      .o_b_rd     (b_rd)
   );

endmodule

//--- verif/run_merger_chk.sv
`include "merge_params.svh"

module run_merger_chk (
   input logic                     i_clk,
   input logic                     i_rst_n,
   input logic                     i_out_full,
   input logic                     i_out_valid,
   input logic [`MERGE_DATA_W-1:0] i_out_data,
   input logic                     i_out_last,
   input logic                     i_a_full,
   input logic                     i_b_full
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;                     // failed assertions so far.

   logic [`MERGE_DATA_W-1:0] prev_data;  // last nonzero word of the open run.
   logic                     prev_open;  // a run has started on the output.

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         prev_data <= '0;
         prev_open <= 1'b0;
      end else if (i_out_valid) begin
         prev_data <= i_out_data;
         prev_open <= !i_out_last;  // terminator closes the run.
      end
   end

   // last marks the zero word and nothing else.
   last_is_term: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_out_last == (i_out_valid && i_out_data == '0))
      else begin
         fail_cnt++;
         $error("last flag and zero terminator disagree");
      end

   // words inside one output run never go down.
   run_sorted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_out_valid && !i_out_last && prev_open) |-> (i_out_data >= prev_data))
      else begin
         fail_cnt++;
         $error("output run is not non-decreasing");
      end

   stall_gap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_out_full |=> !i_out_valid)   // one cycle of reaction.
      else begin
         fail_cnt++;
         $error("output word while downstream was full");
      end

   // quiet outputs during reset and on the first edge after it.
   reset_quiet: assert property (@(posedge i_clk)
      (!i_rst_n || $rose(i_rst_n)) |->
         (!i_out_valid && !i_out_last && !i_a_full && !i_b_full))
      else begin
         fail_cnt++;
         $error("outputs or full flags active around reset");
      end

endmodule

//--- verif/run_merger_tb.sv
`include "merge_params.svh"

module run_merger_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES  = 8;
   localparam int FEED_TIMEOUT  = 400;  // cycles per feed call.
   localparam int DRAIN_TIMEOUT = 400;  // cycles per drain wait.
   localparam int MODE_EQUAL    = 0;
   localparam int MODE_UNEQUAL  = 1;
   localparam int MODE_TIES     = 2;
   localparam int MODE_BP       = 3;
   localparam int MODE_FILL     = 4;

   logic                     clk;
   logic                     rst_n;
   logic                     a_wr;
   logic [`MERGE_DATA_W-1:0] a_data;
   logic                     b_wr;
   logic [`MERGE_DATA_W-1:0] b_data;
   logic                     out_full = 1'b0;
   logic                     a_full;
   logic                     b_full;
   logic                     out_valid;
   logic [`MERGE_DATA_W-1:0] out_data;
   logic                     out_last;

   logic [31:0]              lcg_state = 32'h1d64391a;  // stimulus stream.
   logic [31:0]              bp_state  = 32'h1d64391a;  // back-pressure stream.
   logic [`MERGE_DATA_W-1:0] a_src [$];   // words still to write into a.
   logic [`MERGE_DATA_W-1:0] b_src [$];
   logic [`MERGE_DATA_W-1:0] exp_q [$];   // model output, indexed by got_cnt.
   logic [`MERGE_DATA_W-1:0] exp_word;
   int                       test_pairs [5] = '{4, 6, 5, 6, 3};  // run pairs per mode.
   int                       got_cnt     = 0;
   int                       mon_err_cnt = 0;
   int                       tb_err_cnt  = 0;
   int                       tests_run   = 0;
   int                       tests_bad   = 0;
   bit                       bp_on       = 1'b0;
   bit                       timed_out   = 1'b0;

   run_merger_top run_merger_top_i (
      .i_clk(clk), .i_rst_n(rst_n),
      .i_a_wr(a_wr), .i_a_data(a_data), .i_b_wr(b_wr), .i_b_data(b_data),
      .i_out_full(out_full), .o_a_full(a_full), .o_b_full(b_full),
      .o_out_valid(out_valid), .o_out_data(out_data), .o_out_last(out_last)
   );

   bind run_merger_top run_merger_chk u_chk (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_out_full(i_out_full),
      .i_out_valid(o_out_valid), .i_out_data(o_out_data), .i_out_last(o_out_last),
      .i_a_full(o_a_full), .i_b_full(o_b_full)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns period.
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // upper bits, the low ones of an lcg are weak.
   function automatic int rand_below(input int n);
      lcg_state = lcg_step(lcg_state);
      return int'(lcg_state[30:16]) % n;
   endfunction

   function automatic int total_errs();
      return tb_err_cnt + mon_err_cnt + run_merger_top_i.u_chk.fail_cnt;
   endfunction

   // random downstream full level.
   always @(posedge clk) begin
      bp_state <= lcg_step(bp_state);
      out_full <= bp_on && bp_state[20];
   end

   // compare every output word with the model, between edges.
   always @(negedge clk) begin
      if (rst_n && out_valid) begin
         if (got_cnt >= exp_q.size()) begin
            $display("ERROR %0t: unexpected output word %h", $time, out_data);
            mon_err_cnt++;
         end else begin
            exp_word = exp_q[got_cnt];
            word_match: assert (out_data == exp_word && out_last == (exp_word == '0)) else begin
               $display("ERROR %0t: word %0d is %h last %b, expected %h", $time, got_cnt,
                        out_data, out_last, exp_word);
               mon_err_cnt++;
            end
            got_cnt++;
         end
      end
   end

   // random run pairs plus the expected merge of each pair.
   task automatic build_pairs(input int n_pairs, input int mode);
      logic [`MERGE_DATA_W-1:0] a_run [$];
      logic [`MERGE_DATA_W-1:0] b_run [$];
      int len_a;
      int len_b;
      int step;
      int val;
      int ia;
      int ib;
      step = (mode == MODE_TIES) ? 2 : 20;  // small steps give duplicates.
      for (int p = 0; p < n_pairs; p++) begin
         len_a = rand_below(6);
         len_b = (mode == MODE_EQUAL) ? len_a : rand_below(6);
         if (mode == MODE_EQUAL && len_a == 0) begin
            len_a = 3;
            len_b = 3;
         end
         if (mode == MODE_UNEQUAL && p == 0) len_a = 0;  // a holds only its terminator.
         if (mode == MODE_UNEQUAL && p == 1) len_b = 0;
         if (mode == MODE_FILL) len_a = 3 + rand_below(3);  // enough to fill fifo a.
         a_run.delete();
         b_run.delete();
         val = 1 + rand_below(4);
         for (int i = 0; i < len_a; i++) begin
            val += rand_below(step);
            a_run.push_back(val[`MERGE_DATA_W-1:0]);
         end
         val = 1 + rand_below(4);
         for (int i = 0; i < len_b; i++) begin
            val += rand_below(step);
            b_run.push_back(val[`MERGE_DATA_W-1:0]);
         end
         foreach (a_run[i]) a_src.push_back(a_run[i]);
         foreach (b_run[i]) b_src.push_back(b_run[i]);
         a_src.push_back('0);
         b_src.push_back('0);
         ia = 0;
         ib = 0;
         while (ia < a_run.size() || ib < b_run.size()) begin
            if (ib >= b_run.size() || (ia < a_run.size() && a_run[ia] <= b_run[ib])) begin
               exp_q.push_back(a_run[ia]);  // ties from a first.
               ia++;
            end else begin
               exp_q.push_back(b_run[ib]);
               ib++;
            end
         end
         exp_q.push_back('0);  // one terminator per pair.
      end
   endtask

   // writes never come back to back, so the full flag seen here is current.
   task automatic feed_streams(input bit a_only);
      int guard;
      guard = 0;
      while (!timed_out && (a_src.size() != 0 || (!a_only && b_src.size() != 0))) begin
         @(posedge clk);
         if (a_only && a_full) begin
            a_wr <= 1'b0;
            break;
         end
         if (a_src.size() != 0 && !a_wr && !a_full && rand_below(4) != 0) begin
            a_wr   <= 1'b1;
            a_data <= a_src.pop_front();
         end else begin
            a_wr <= 1'b0;
         end
         if (!a_only && b_src.size() != 0 && !b_wr && !b_full && rand_below(4) != 0) begin
            b_wr   <= 1'b1;
            b_data <= b_src.pop_front();
         end else begin
            b_wr <= 1'b0;
         end
         guard++;
         if (guard >= FEED_TIMEOUT) begin
            $display("timeout: input words could not be written within %0d cycles", guard);
            tb_err_cnt++;
            timed_out = 1'b1;
         end
      end
      @(posedge clk);
      a_wr <= 1'b0;
      b_wr <= 1'b0;
   endtask

   task automatic wait_drain();
      int guard;
      guard = 0;
      while (got_cnt < exp_q.size() && guard < DRAIN_TIMEOUT) begin
         @(posedge clk);
         guard++;
      end
      if (got_cnt < exp_q.size()) begin
         $display("timeout: %0d expected words never left the merger", exp_q.size() - got_cnt);
         tb_err_cnt++;
         timed_out = 1'b1;
      end
      repeat (3) @(posedge clk);  // room for a stray extra word.
   endtask

   task automatic run_test(input int num);
      int    errs_before;
      int    words_before;
      int    mode;
      string name;
      errs_before  = total_errs();
      words_before = got_cnt;
      mode         = num - 1;  // tests 1 to 5 follow the mode order.
      case (mode)
         MODE_EQUAL:   name = "basic";
         MODE_UNEQUAL: name = "unequal";
         MODE_TIES:    name = "ties";
         MODE_BP:      name = "backpres";
         default:      name = "fifofill";
      endcase
      build_pairs(test_pairs[mode], mode);
      bp_on <= (mode == MODE_BP);
      if (mode == MODE_FILL) begin
         feed_streams(1'b1);  // b stays empty, nothing may come out.
         repeat (4) @(posedge clk);
         fill_hold: assert (a_full && got_cnt == words_before) else begin
            $display("ERROR %0t: fifo a full %b with %0d words out while b was empty",
                     $time, a_full, got_cnt - words_before);
            tb_err_cnt++;
         end
      end
      feed_streams(1'b0);
      if (!timed_out) wait_drain();
      bp_on <= 1'b0;
      tests_run++;
      if (total_errs() != errs_before) tests_bad++;
      $display("test %0d %s %s, %0d words", num, name,
               (total_errs() == errs_before) ? "ok" : "bad", got_cnt - words_before);
   endtask

   initial begin
      rst_n  = 1'b0;
      a_wr   = 1'b0;
      a_data = '0;
      b_wr   = 1'b0;
      b_data = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      for (int t = 1; t <= 5; t++) begin
         if (!timed_out) run_test(t);
      end
      $display("tests run %0d, failed %0d, words checked %0d, errors %0d",
               tests_run, tests_bad, got_cnt, total_errs());
      if (total_errs() == 0 && !timed_out) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
